//--- design/gat_bram.sv
// Read data appears one cycle after rd_addr; a same-address write and read returns the old word
`timescale 1ns/1ns

module gat_bram #(
  parameter int DEPTH = 32,
  parameter int WIDTH = 8
) (
  input  logic                      clk,
  input  logic                      wr_en,
  input  logic [$clog2(DEPTH)-1:0]  wr_addr,
  input  logic [WIDTH-1:0]          wr_data,
  input  logic [$clog2(DEPTH)-1:0]  rd_addr,
  output logic [WIDTH-1:0]          rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- design/gat_cfg_pkg.sv
// Fixed sizes only (8 nodes, 4 in, 4 hidden, 3 final); changing them also changes the memory map
package gat_cfg_pkg;

  // ==============================
  // Graph and layer dimensions
  // ==============================
  localparam int TOTAL_NODES       = 8;
  localparam int NUM_FEATURE_IN    = 4;
  localparam int NUM_FEATURE_OUT   = 4;
  localparam int NUM_FEATURE_FINAL = 3;

  // Signed operands, weights and results
  localparam int DATA_WIDTH        = 8;
  localparam int NEW_FEATURE_WIDTH = 32;

  // ==============================
  // Memory map
  // ==============================
  // H is node-major, h[n][i] at n*NUM_FEATURE_IN + i
  localparam int H_DEPTH = TOTAL_NODES * NUM_FEATURE_IN;

  // Layer-1 weights first, layer-2 weights right behind them
  localparam int WGT_BASE_CONV2 = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int WGT_DEPTH      = WGT_BASE_CONV2 + NUM_FEATURE_OUT * NUM_FEATURE_FINAL;

  // out1 region, then out2 region
  localparam int FEAT_BASE_CONV2 = TOTAL_NODES * NUM_FEATURE_OUT;
  localparam int FEAT_DEPTH      = FEAT_BASE_CONV2 + TOTAL_NODES * NUM_FEATURE_FINAL;

  // Address widths
  localparam int H_ADDR_W    = $clog2(H_DEPTH);
  localparam int WGT_ADDR_W  = $clog2(WGT_DEPTH);
  localparam int FEAT_ADDR_W = $clog2(FEAT_DEPTH);

endpackage

//--- design/gat_layer_engine.sv
// Needs one-cycle read latency on both operand ports; source and destination regions must not overlap
`timescale 1ns/1ns

module gat_layer_engine #(
  parameter int NUM_IN   = 4,
  parameter int NUM_OUT  = 4,
  parameter int WGT_BASE = 0,
  parameter int SRC_BASE = 0,
  parameter int DST_BASE = 0
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                start,
  output gat_mem_pkg::opnd_rd_t               opnd_rd,
  output gat_mem_pkg::wgt_rd_t                wgt_rd,
  input  logic [gat_cfg_pkg::DATA_WIDTH-1:0]  opnd_data,
  input  logic [gat_cfg_pkg::DATA_WIDTH-1:0]  wgt_data,
  output gat_mem_pkg::feat_wr_t               feat_wr,
  output logic                                busy,
  output logic                                done
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WAIT,
    S_WRITE
  } state_t;

  state_t state;

  logic [$clog2(gat_cfg_pkg::TOTAL_NODES+1)-1:0] n_cnt;
  logic [$clog2(NUM_OUT+1)-1:0]                  j_cnt;
  logic [$clog2(NUM_IN+1)-1:0]                   i_cnt;
  logic                                          last_pair;

  // Full-width address sums, sliced down to the port widths
  logic [31:0] opnd_addr_full;
  logic [31:0] wgt_addr_full;
  logic [31:0] dst_addr_full;

  // Read pipeline tags, aligned with the returning data
  logic rd_valid;
  logic rd_first;

  logic signed [2*gat_cfg_pkg::DATA_WIDTH-1:0]  product;
  logic signed [gat_cfg_pkg::NEW_FEATURE_WIDTH-1:0] product_ext;
  logic signed [gat_cfg_pkg::NEW_FEATURE_WIDTH-1:0] acc;

  // ==============================
  // Address generation
  // ==============================
  assign opnd_addr_full = SRC_BASE + n_cnt * NUM_IN + i_cnt;
  assign wgt_addr_full  = WGT_BASE + i_cnt * NUM_OUT + j_cnt;
  assign dst_addr_full  = DST_BASE + n_cnt * NUM_OUT + j_cnt;

  assign opnd_rd.en   = (state == S_READ);
  assign opnd_rd.addr = opnd_addr_full[gat_cfg_pkg::FEAT_ADDR_W-1:0];
  assign wgt_rd.en    = (state == S_READ);
  assign wgt_rd.addr  = wgt_addr_full[gat_cfg_pkg::WGT_ADDR_W-1:0];

  // Result goes out in the cycle after the last product lands
  assign feat_wr.en   = (state == S_WRITE);
  assign feat_wr.addr = dst_addr_full[gat_cfg_pkg::FEAT_ADDR_W-1:0];
  assign feat_wr.data = acc;

  assign last_pair = (n_cnt == gat_cfg_pkg::TOTAL_NODES - 1) && (j_cnt == NUM_OUT - 1);

  // ==============================
  // Sequencer
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      n_cnt    <= '0;
      j_cnt    <= '0;
      i_cnt    <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
      rd_valid <= 1'b0;
      rd_first <= 1'b0;
    end else begin
      done     <= 1'b0;
      rd_valid <= (state == S_READ);
      rd_first <= (state == S_READ) && (i_cnt == '0);
      case (state)
        S_IDLE: begin
          if (start) begin
            busy  <= 1'b1;
            n_cnt <= '0;
            j_cnt <= '0;
            i_cnt <= '0;
            state <= S_READ;
          end
        end
        S_READ: begin
          if (i_cnt == NUM_IN - 1) begin
            i_cnt <= '0;
            state <= S_WAIT;
          end else begin
            i_cnt <= i_cnt + 1'b1;
          end
        end
        // Last product still in the RAM output register
        S_WAIT: begin
          state <= S_WRITE;
        end
        S_WRITE: begin
          if (last_pair) begin
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= S_IDLE;
          end else begin
            state <= S_READ;
            if (j_cnt == NUM_OUT - 1) begin
              j_cnt <= '0;
              n_cnt <= n_cnt + 1'b1;
            end else begin
              j_cnt <= j_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ==============================
  // Multiply-accumulate
  // ==============================
  assign product     = $signed(opnd_data) * $signed(wgt_data);
  assign product_ext = {{(gat_cfg_pkg::NEW_FEATURE_WIDTH-2*gat_cfg_pkg::DATA_WIDTH)
                         {product[2*gat_cfg_pkg::DATA_WIDTH-1]}}, product};

  // First product of a pair restarts the sum
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      if (rd_first) begin
        acc <= product_ext;
      end else begin
        acc <= acc + product_ext;
      end
    end
  end

endmodule

//--- design/gat_mem_pkg.sv
// Port bundles for the shared RAMs; an engine operand address spans the whole feature map
package gat_mem_pkg;

  // ==============================
  // Host write ports
  // ==============================
  typedef struct packed {
    logic                                  en;
    logic [gat_cfg_pkg::H_ADDR_W-1:0]      addr;
    logic [gat_cfg_pkg::DATA_WIDTH-1:0]    data;
  } h_wr_t;

  typedef struct packed {
    logic                                  en;
    logic [gat_cfg_pkg::WGT_ADDR_W-1:0]    addr;
    logic [gat_cfg_pkg::DATA_WIDTH-1:0]    data;
  } wgt_wr_t;

  // ==============================
  // Engine ports
  // ==============================
  // Result write into the feature RAM
  typedef struct packed {
    logic                                       en;
    logic [gat_cfg_pkg::FEAT_ADDR_W-1:0]        addr;
    logic [gat_cfg_pkg::NEW_FEATURE_WIDTH-1:0]  data;
  } feat_wr_t;

  // Operand fetch, H for layer 1 or features for layer 2
  typedef struct packed {
    logic                                  en;
    logic [gat_cfg_pkg::FEAT_ADDR_W-1:0]   addr;
  } opnd_rd_t;

  // Weight fetch
  typedef struct packed {
    logic                                  en;
    logic [gat_cfg_pkg::WGT_ADDR_W-1:0]    addr;
  } wgt_rd_t;

endpackage

//--- design/gat_top.sv
// Host writes H and weights only while gat_ready is high or before the first start
`timescale 1ns/1ns

module gat_top (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       gat_layer,
  input  logic                                       gat_start,
  output logic                                       gat_ready,
  input  gat_mem_pkg::h_wr_t                         h_wr,
  input  gat_mem_pkg::wgt_wr_t                       wgt_wr,
  input  logic [gat_cfg_pkg::FEAT_ADDR_W-1:0]        feat_bram_addrb,
  output logic [gat_cfg_pkg::NEW_FEATURE_WIDTH-1:0]  feat_bram_dout
);

  // Memory side
  logic [gat_cfg_pkg::H_ADDR_W-1:0]          h_rd_addr;
  logic [gat_cfg_pkg::DATA_WIDTH-1:0]        h_rd_data;
  logic [gat_cfg_pkg::WGT_ADDR_W-1:0]        wgt_rd_addr;
  logic [gat_cfg_pkg::DATA_WIDTH-1:0]        wgt_rd_data;
  gat_mem_pkg::feat_wr_t                     feat_wr;
  logic [gat_cfg_pkg::FEAT_ADDR_W-1:0]       feat_rd_addr;
  logic [gat_cfg_pkg::NEW_FEATURE_WIDTH-1:0] feat_rd_data;

  // Engine side
  gat_mem_pkg::opnd_rd_t               opnd_rd1;
  gat_mem_pkg::opnd_rd_t               opnd_rd2;
  gat_mem_pkg::wgt_rd_t                wgt_rd1;
  gat_mem_pkg::wgt_rd_t                wgt_rd2;
  gat_mem_pkg::feat_wr_t               feat_wr1;
  gat_mem_pkg::feat_wr_t               feat_wr2;
  logic [gat_cfg_pkg::DATA_WIDTH-1:0]  opnd_data;
  logic [gat_cfg_pkg::DATA_WIDTH-1:0]  wgt_data;
  logic                                busy1;
  logic                                busy2;
  logic                                done1;
  logic                                done2;
  logic                                start1;
  logic                                start2;

  assign start1 = gat_start & ~gat_layer;
  assign start2 = gat_start & gat_layer;

  // Only the started engine can pulse done
  always_ff @(posedge clk) begin
    if (reset) begin
      gat_ready <= 1'b0;
    end else if (gat_start) begin
      gat_ready <= 1'b0;
    end else if (done1 | done2) begin
      gat_ready <= 1'b1;
    end
  end

  assign feat_bram_dout = feat_rd_data;

  // ==============================
  // Memories
  // ==============================
  gat_bram #(
    .DEPTH (gat_cfg_pkg::H_DEPTH),
    .WIDTH (gat_cfg_pkg::DATA_WIDTH)
  ) u_h_bram (
    .clk     (clk),
    .wr_en   (h_wr.en),
    .wr_addr (h_wr.addr),
    .wr_data (h_wr.data),
    .rd_addr (h_rd_addr),
    .rd_data (h_rd_data)
  );

  gat_bram #(
    .DEPTH (gat_cfg_pkg::WGT_DEPTH),
    .WIDTH (gat_cfg_pkg::DATA_WIDTH)
  ) u_wgt_bram (
    .clk     (clk),
    .wr_en   (wgt_wr.en),
    .wr_addr (wgt_wr.addr),
    .wr_data (wgt_wr.data),
    .rd_addr (wgt_rd_addr),
    .rd_data (wgt_rd_data)
  );

  gat_bram #(
    .DEPTH (gat_cfg_pkg::FEAT_DEPTH),
    .WIDTH (gat_cfg_pkg::NEW_FEATURE_WIDTH)
  ) u_feat_bram (
    .clk     (clk),
    .wr_en   (feat_wr.en),
    .wr_addr (feat_wr.addr),
    .wr_data (feat_wr.data),
    .rd_addr (feat_rd_addr),
    .rd_data (feat_rd_data)
  );

  // ==============================
  // Arbiter
  // ==============================
  memory_arbiter u_memory_arbiter (
    .clk             (clk),
    .reset           (reset),
    .gat_start       (gat_start),
    .gat_layer       (gat_layer),
    .busy1           (busy1),
    .busy2           (busy2),
    .opnd_rd1        (opnd_rd1),
    .opnd_rd2        (opnd_rd2),
    .wgt_rd1         (wgt_rd1),
    .wgt_rd2         (wgt_rd2),
    .feat_wr1        (feat_wr1),
    .feat_wr2        (feat_wr2),
    .feat_bram_addrb (feat_bram_addrb),
    .h_rd_addr       (h_rd_addr),
    .h_rd_data       (h_rd_data),
    .wgt_rd_addr     (wgt_rd_addr),
    .wgt_rd_data     (wgt_rd_data),
    .feat_wr         (feat_wr),
    .feat_rd_addr    (feat_rd_addr),
    .feat_rd_data    (feat_rd_data),
    .opnd_data       (opnd_data),
    .wgt_data        (wgt_data)
  );

  // ==============================
  // Layer engines
  // ==============================
  gat_layer_engine #(
    .NUM_IN   (gat_cfg_pkg::NUM_FEATURE_IN),
    .NUM_OUT  (gat_cfg_pkg::NUM_FEATURE_OUT),
    .WGT_BASE (0),
    .SRC_BASE (0),
    .DST_BASE (0)
  ) u_gat_conv1 (
    .clk       (clk),
    .reset     (reset),
    .start     (start1),
    .opnd_rd   (opnd_rd1),
    .wgt_rd    (wgt_rd1),
    .opnd_data (opnd_data),
    .wgt_data  (wgt_data),
    .feat_wr   (feat_wr1),
    .busy      (busy1),
    .done      (done1)
  );

  // Reads the out1 region, writes the out2 region
  gat_layer_engine #(
    .NUM_IN   (gat_cfg_pkg::NUM_FEATURE_OUT),
    .NUM_OUT  (gat_cfg_pkg::NUM_FEATURE_FINAL),
    .WGT_BASE (gat_cfg_pkg::WGT_BASE_CONV2),
    .SRC_BASE (0),
    .DST_BASE (gat_cfg_pkg::FEAT_BASE_CONV2)
  ) u_gat_conv2 (
    .clk       (clk),
    .reset     (reset),
    .start     (start2),
    .opnd_rd   (opnd_rd2),
    .wgt_rd    (wgt_rd2),
    .opnd_data (opnd_data),
    .wgt_data  (wgt_data),
    .feat_wr   (feat_wr2),
    .busy      (busy2),
    .done      (done2)
  );

endmodule

//--- design/memory_arbiter.sv
// Layer is latched at gat_start; a second start during a run is not guarded against
`timescale 1ns/1ns

module memory_arbiter (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       gat_start,
  input  logic                                       gat_layer,
  input  logic                                       busy1,
  input  logic                                       busy2,
  input  gat_mem_pkg::opnd_rd_t                      opnd_rd1,
  input  gat_mem_pkg::opnd_rd_t                      opnd_rd2,
  input  gat_mem_pkg::wgt_rd_t                       wgt_rd1,
  input  gat_mem_pkg::wgt_rd_t                       wgt_rd2,
  input  gat_mem_pkg::feat_wr_t                      feat_wr1,
  input  gat_mem_pkg::feat_wr_t                      feat_wr2,
  input  logic [gat_cfg_pkg::FEAT_ADDR_W-1:0]        feat_bram_addrb,
  output logic [gat_cfg_pkg::H_ADDR_W-1:0]           h_rd_addr,
  input  logic [gat_cfg_pkg::DATA_WIDTH-1:0]         h_rd_data,
  output logic [gat_cfg_pkg::WGT_ADDR_W-1:0]         wgt_rd_addr,
  input  logic [gat_cfg_pkg::DATA_WIDTH-1:0]         wgt_rd_data,
  output gat_mem_pkg::feat_wr_t                      feat_wr,
  output logic [gat_cfg_pkg::FEAT_ADDR_W-1:0]        feat_rd_addr,
  input  logic [gat_cfg_pkg::NEW_FEATURE_WIDTH-1:0]  feat_rd_data,
  output logic [gat_cfg_pkg::DATA_WIDTH-1:0]         opnd_data,
  output logic [gat_cfg_pkg::DATA_WIDTH-1:0]         wgt_data
);

  logic                   layer_q;
  logic                   engine_busy;
  gat_mem_pkg::opnd_rd_t  opnd_sel;
  gat_mem_pkg::wgt_rd_t   wgt_sel;

  // Bits above the operand sign; all equal when the value fits in DATA_WIDTH
  logic [gat_cfg_pkg::NEW_FEATURE_WIDTH-gat_cfg_pkg::DATA_WIDTH:0] feat_hi;
  logic [gat_cfg_pkg::DATA_WIDTH-1:0]                            feat_sat;

  // ==============================
  // Layer select
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      layer_q <= 1'b0;
    end else if (gat_start) begin
      layer_q <= gat_layer;
    end
  end

  assign engine_busy = busy1 | busy2;

  // ==============================
  // Request routing
  // ==============================
  assign opnd_sel = layer_q ? opnd_rd2 : opnd_rd1;
  assign wgt_sel  = layer_q ? wgt_rd2  : wgt_rd1;
  assign feat_wr  = layer_q ? feat_wr2 : feat_wr1;

  // Idle read ports park at address zero
  assign h_rd_addr   = opnd_sel.en ? opnd_sel.addr[gat_cfg_pkg::H_ADDR_W-1:0] : '0;
  assign wgt_rd_addr = wgt_sel.en ? wgt_sel.addr : '0;

  // Port B goes back to the host once both engines are idle
  assign feat_rd_addr = engine_busy ? opnd_sel.addr : feat_bram_addrb;

  // ==============================
  // Read data return
  // ==============================
  assign feat_hi = feat_rd_data[gat_cfg_pkg::NEW_FEATURE_WIDTH-1:gat_cfg_pkg::DATA_WIDTH-1];

  always_comb begin
    if ((feat_hi == '0) || (feat_hi == '1)) begin
      feat_sat = feat_rd_data[gat_cfg_pkg::DATA_WIDTH-1:0];
    end else if (feat_rd_data[gat_cfg_pkg::NEW_FEATURE_WIDTH-1]) begin
      feat_sat = {1'b1, {(gat_cfg_pkg::DATA_WIDTH-1){1'b0}}};
    end else begin
      feat_sat = {1'b0, {(gat_cfg_pkg::DATA_WIDTH-1){1'b1}}};
    end
  end

  assign opnd_data = layer_q ? feat_sat : h_rd_data;
  assign wgt_data  = wgt_rd_data;

endmodule

//--- tb.f
design/gat_cfg_pkg.sv
design/gat_mem_pkg.sv
design/gat_bram.sv
design/memory_arbiter.sv
design/gat_layer_engine.sv
design/gat_top.sv
verif/gat_clock_gen.sv
verif/gat_tb.sv

//--- verif/gat_clock_gen.sv
// Free-running 100 ns clock; reset is held high for the first 8 rising edges only
`timescale 1ns/1ns

module gat_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- verif/gat_tb.sv
// Dense two-layer checks only; host reads are pipelined one address per cycle and checked on negedge
`timescale 1ns/1ns

module gat_tb;

  localparam int READY_TIMEOUT = 2000;
  localparam int RESET_TIMEOUT = 50;

  logic                                       clk;
  logic                                       reset;
  logic                                       gat_layer;
  logic                                       gat_start;
  logic                                       gat_ready;
  gat_mem_pkg::h_wr_t                         h_wr;
  gat_mem_pkg::wgt_wr_t                       wgt_wr;
  logic [gat_cfg_pkg::FEAT_ADDR_W-1:0]        feat_bram_addrb;
  logic [gat_cfg_pkg::NEW_FEATURE_WIDTH-1:0]  feat_bram_dout;

  // Reference copies of the loaded data and the expected results
  int h_ref    [gat_cfg_pkg::TOTAL_NODES][gat_cfg_pkg::NUM_FEATURE_IN];
  int w1_ref   [gat_cfg_pkg::NUM_FEATURE_IN][gat_cfg_pkg::NUM_FEATURE_OUT];
  int w2_ref   [gat_cfg_pkg::NUM_FEATURE_OUT][gat_cfg_pkg::NUM_FEATURE_FINAL];
  int out1_exp [gat_cfg_pkg::TOTAL_NODES][gat_cfg_pkg::NUM_FEATURE_OUT];
  int out2_exp [gat_cfg_pkg::TOTAL_NODES][gat_cfg_pkg::NUM_FEATURE_FINAL];

  logic [31:0] lcg_state;
  string       test_name;
  int          errors;
  int          checks;

  // Read request pipeline toward the compare process
  logic rd_req;
  int   rd_exp;
  int   rd_addr;
  logic chk_valid;
  int   chk_exp;
  int   chk_addr;

  gat_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  gat_top dut (
    .clk             (clk),
    .reset           (reset),
    .gat_layer       (gat_layer),
    .gat_start       (gat_start),
    .gat_ready       (gat_ready),
    .h_wr            (h_wr),
    .wgt_wr          (wgt_wr),
    .feat_bram_addrb (feat_bram_addrb),
    .feat_bram_dout  (feat_bram_dout)
  );

  // ==============================
  // Stimulus helpers
  // ==============================
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic next_rand(output logic [7:0] value);
    lcg_state = lcg_next(lcg_state);
    value = lcg_state[23:16];
  endtask

  task automatic fill_h();
    logic [7:0] b;
    for (int n = 0; n < gat_cfg_pkg::TOTAL_NODES; n++) begin
      for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_IN; i++) begin
        next_rand(b);
        h_ref[n][i] = $signed(b[4:0]);
      end
    end
  endtask

  // Columns 0 and 1 stay small, the rest use full-range weights
  task automatic fill_w1();
    logic [7:0] b;
    for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_IN; i++) begin
      for (int j = 0; j < gat_cfg_pkg::NUM_FEATURE_OUT; j++) begin
        next_rand(b);
        if (j < 2) begin
          w1_ref[i][j] = $signed(b[2:0]);
        end else begin
          w1_ref[i][j] = $signed(b);
        end
      end
    end
  endtask

  task automatic fill_w2();
    logic [7:0] b;
    for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_OUT; i++) begin
      for (int j = 0; j < gat_cfg_pkg::NUM_FEATURE_FINAL; j++) begin
        next_rand(b);
        w2_ref[i][j] = $signed(b);
      end
    end
  endtask

  task automatic load_h();
    for (int n = 0; n < gat_cfg_pkg::TOTAL_NODES; n++) begin
      for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_IN; i++) begin
        @(posedge clk);
        h_wr.en   <= 1'b1;
        h_wr.addr <= n * gat_cfg_pkg::NUM_FEATURE_IN + i;
        h_wr.data <= h_ref[n][i][7:0];
      end
    end
    @(posedge clk);
    h_wr.en <= 1'b0;
  endtask

  task automatic load_weights();
    for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_IN; i++) begin
      for (int j = 0; j < gat_cfg_pkg::NUM_FEATURE_OUT; j++) begin
        @(posedge clk);
        wgt_wr.en   <= 1'b1;
        wgt_wr.addr <= i * gat_cfg_pkg::NUM_FEATURE_OUT + j;
        wgt_wr.data <= w1_ref[i][j][7:0];
      end
    end
    for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_OUT; i++) begin
      for (int j = 0; j < gat_cfg_pkg::NUM_FEATURE_FINAL; j++) begin
        @(posedge clk);
        wgt_wr.en   <= 1'b1;
        wgt_wr.addr <= gat_cfg_pkg::WGT_BASE_CONV2 + i * gat_cfg_pkg::NUM_FEATURE_FINAL + j;
        wgt_wr.data <= w2_ref[i][j][7:0];
      end
    end
    @(posedge clk);
    wgt_wr.en <= 1'b0;
  endtask

  // ==============================
  // Reference model
  // ==============================
  function automatic int sat8(input int value);
    if (value > 127) begin
      return 127;
    end else if (value < -128) begin
      return -128;
    end
    return value;
  endfunction

  function automatic int ref_layer(input int layer, input int n, input int j);
    int sum;
    sum = 0;
    if (layer == 0) begin
      for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_IN; i++) begin
        sum += h_ref[n][i] * w1_ref[i][j];
      end
    end else begin
      for (int i = 0; i < gat_cfg_pkg::NUM_FEATURE_OUT; i++) begin
        sum += sat8(out1_exp[n][i]) * w2_ref[i][j];
      end
    end
    return sum;
  endfunction

  task automatic compute_out1();
    for (int n = 0; n < gat_cfg_pkg::TOTAL_NODES; n++) begin
      for (int j = 0; j < gat_cfg_pkg::NUM_FEATURE_OUT; j++) begin
        out1_exp[n][j] = ref_layer(0, n, j);
      end
    end
  endtask

  task automatic compute_out2();
    for (int n = 0; n < gat_cfg_pkg::TOTAL_NODES; n++) begin
      for (int j = 0; j < gat_cfg_pkg::NUM_FEATURE_FINAL; j++) begin
        out2_exp[n][j] = ref_layer(1, n, j);
      end
    end
  endtask

  function automatic int expected_at(input int addr);
    int off;
    if (addr < gat_cfg_pkg::FEAT_BASE_CONV2) begin
      return out1_exp[addr / gat_cfg_pkg::NUM_FEATURE_OUT][addr % gat_cfg_pkg::NUM_FEATURE_OUT];
    end
    off = addr - gat_cfg_pkg::FEAT_BASE_CONV2;
    return out2_exp[off / gat_cfg_pkg::NUM_FEATURE_FINAL][off % gat_cfg_pkg::NUM_FEATURE_FINAL];
  endfunction

  // ==============================
  // Run control and host reads
  // ==============================
  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s did not happen in time during %s", what, test_name);
    $display("errors: %0d, checks: %0d", errors + 1, checks);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic run_layer(input logic layer);
    int cycles;
    @(posedge clk);
    gat_layer <= layer;
    gat_start <= 1'b1;
    @(posedge clk);
    gat_start <= 1'b0;
    @(negedge clk);
    assert (gat_ready == 1'b0) else begin
      errors++;
      $display("Error %s: gat_ready expected 0, actual %0b", test_name, gat_ready);
    end
    cycles = 0;
    while ((gat_ready !== 1'b1) && (cycles < READY_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (gat_ready !== 1'b1) begin
      stop_on_timeout("the rise of gat_ready");
    end
  endtask

  // Back-to-back reads at first + (k*stride) mod count
  task automatic sweep(input int first, input int count, input int stride);
    int addr;
    for (int k = 0; k < count; k++) begin
      addr = first + (k * stride) % count;
      @(posedge clk);
      feat_bram_addrb <= addr;
      rd_req          <= 1'b1;
      rd_exp          <= expected_at(addr);
      rd_addr         <= addr;
    end
    @(posedge clk);
    rd_req <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // ==============================
  // Compare process
  // ==============================
  always @(posedge clk) begin
    chk_valid <= rd_req;
    chk_exp   <= rd_exp;
    chk_addr  <= rd_addr;
  end

  always @(negedge clk) begin
    if (chk_valid === 1'b1) begin
      checks++;
      assert ($signed(feat_bram_dout) == chk_exp) else begin
        errors++;
        $display("Error %s addr %0d: expected %0d, actual %0d",
                 test_name, chk_addr, chk_exp, $signed(feat_bram_dout));
      end
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    int cycles;
    int n_sat;
    int n_lin;
    gat_layer       = 1'b0;
    gat_start       = 1'b0;
    h_wr            = '0;
    wgt_wr          = '0;
    feat_bram_addrb = '0;
    rd_req          = 1'b0;
    rd_exp          = 0;
    rd_addr         = 0;
    errors          = 0;
    checks          = 0;
    lcg_state       = 32'h5c2b;
    test_name       = "reset";

    cycles = 0;
    while ((reset !== 1'b0) && (cycles < RESET_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (reset !== 1'b0) begin
      stop_on_timeout("the release of reset");
    end
    @(negedge clk);
    assert (gat_ready == 1'b0) else begin
      errors++;
      $display("Error %s: gat_ready expected 0, actual %0b", test_name, gat_ready);
    end

    test_name = "layer1";
    fill_h();
    fill_w1();
    fill_w2();
    load_h();
    load_weights();
    compute_out1();
    run_layer(1'b0);
    sweep(0, gat_cfg_pkg::FEAT_BASE_CONV2, 1);

    // Layer 2 must see both clipped and in-range operands
    test_name = "layer2";
    n_sat = 0;
    n_lin = 0;
    foreach (out1_exp[n, i]) begin
      if (sat8(out1_exp[n][i]) != out1_exp[n][i]) begin
        n_sat++;
      end else begin
        n_lin++;
      end
    end
    assert ((n_sat > 0) && (n_lin > 0)) else begin
      errors++;
      $display("Layer-2 operands are not a mix of saturated and in-range values");
    end
    compute_out2();
    run_layer(1'b1);
    sweep(gat_cfg_pkg::FEAT_BASE_CONV2,
          gat_cfg_pkg::FEAT_DEPTH - gat_cfg_pkg::FEAT_BASE_CONV2, 1);

    // New layer-1 weights; out2 expectations stay as they were
    test_name = "layer1_rerun";
    fill_w1();
    load_weights();
    compute_out1();
    run_layer(1'b0);
    sweep(0, gat_cfg_pkg::FEAT_DEPTH, 1);

    test_name = "host_read";
    sweep(0, gat_cfg_pkg::FEAT_DEPTH, 5);

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
